/* hw/dispatch_stage.sv */
//////////////////////////////////////////////////
// Dispatch stage
// Pops the buffer, decodes the opcode class and
// destination, halts for good after WFI
//////////////////////////////////////////////////

module dispatch_stage (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         dispatch_en,
    input  logic                         ib_valid,
    input  vs_frontend_pkg::addr_t       ib_pc,
    input  vs_frontend_pkg::inst_t       ib_inst,
    output logic                         ib_pop,
    output logic                         dp_valid,
    output vs_frontend_pkg::addr_t       dp_pc,
    output vs_frontend_pkg::inst_t       dp_inst,
    output vs_frontend_pkg::inst_class_t dp_class,
    output logic                         dp_has_dest,
    output vs_frontend_pkg::reg_idx_t    dp_dest_reg,
    output logic                         dp_illegal,
    output logic                         halted
);

    logic [6:0]                   opcode;
    vs_frontend_pkg::reg_idx_t    rd;
    vs_frontend_pkg::inst_class_t dec_class;
    logic                         dec_illegal;
    logic                         dec_has_dest;
    vs_frontend_pkg::reg_idx_t    dec_dest_reg;
    logic                         is_wfi;

    // Pop when back end allows and a head is present
    assign ib_pop = dispatch_en && ib_valid && !halted;

    assign opcode = ib_inst[6:0];
    assign rd     = ib_inst[11:7];
    assign is_wfi = (ib_inst == vs_frontend_pkg::inst_wfi);

    //////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////
    always_comb begin
        case (opcode)
            vs_frontend_pkg::opc_lui:    dec_class = vs_frontend_pkg::cls_lui;
            vs_frontend_pkg::opc_auipc:  dec_class = vs_frontend_pkg::cls_auipc;
            vs_frontend_pkg::opc_jal:    dec_class = vs_frontend_pkg::cls_jal;
            vs_frontend_pkg::opc_jalr:   dec_class = vs_frontend_pkg::cls_jalr;
            vs_frontend_pkg::opc_branch: dec_class = vs_frontend_pkg::cls_branch;
            vs_frontend_pkg::opc_load:   dec_class = vs_frontend_pkg::cls_load;
            vs_frontend_pkg::opc_store:  dec_class = vs_frontend_pkg::cls_store;
            vs_frontend_pkg::opc_op_imm: dec_class = vs_frontend_pkg::cls_op_imm;
            vs_frontend_pkg::opc_op:     dec_class = vs_frontend_pkg::cls_op;
            vs_frontend_pkg::opc_system: dec_class = vs_frontend_pkg::cls_system;
            default:                     dec_class = vs_frontend_pkg::cls_illegal;
        endcase

        // Compressed or reserved encodings, or unknown opcode
        dec_illegal = (ib_inst[1:0] != 2'b11) ||
                      (dec_class == vs_frontend_pkg::cls_illegal);

        // Classes that write rd
        case (dec_class)
            vs_frontend_pkg::cls_lui,
            vs_frontend_pkg::cls_auipc,
            vs_frontend_pkg::cls_jal,
            vs_frontend_pkg::cls_jalr,
            vs_frontend_pkg::cls_load,
            vs_frontend_pkg::cls_op_imm,
            vs_frontend_pkg::cls_op: dec_has_dest = (rd != vs_frontend_pkg::zero_reg);
            default:                 dec_has_dest = 1'b0;
        endcase

        // x0 writes dropped
        dec_dest_reg = dec_has_dest ? rd : vs_frontend_pkg::zero_reg;
    end

    //////////////////////////////////////////////////
    // Registered dispatch outputs
    //////////////////////////////////////////////////

    // Control, one dp_valid per pop
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            dp_valid <= ib_pop;
            // Sticky until reset
            if (ib_pop && is_wfi) begin
                halted <= 1'b1;
            end
        end
    end

    // Payload, only meaningful alongside dp_valid
    always_ff @(posedge clock) begin
        if (ib_pop) begin
            dp_pc       <= ib_pc;
            dp_inst     <= ib_inst;
            dp_class    <= dec_class;
            dp_has_dest <= dec_has_dest;
            dp_dest_reg <= dec_dest_reg;
            dp_illegal  <= dec_illegal;
        end
    end

endmodule

/* hw/fetch_stage.sv */
//////////////////////////////////////////////////
// Fetch stage
// Owns the PC, shares the memory port with data
// requests and pushes fetched words to the buffer
//////////////////////////////////////////////////

module fetch_stage (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            squash,
    input  vs_frontend_pkg::addr_t          squash_pc,
    input  logic                            ib_full,
    input  vs_frontend_pkg::bus_cmd_t       dmem_command,
    input  vs_frontend_pkg::addr_t          dmem_addr,
    input  logic [vs_frontend_pkg::xlen-1:0] dmem_data,
    input  vs_frontend_pkg::mem_line_t      mem2proc_data,
    output vs_frontend_pkg::bus_cmd_t       proc2mem_command,
    output vs_frontend_pkg::addr_t          proc2mem_addr,
    output vs_frontend_pkg::mem_line_t      proc2mem_data,
    output logic                            if_valid,
    output vs_frontend_pkg::addr_t          if_pc,
    output vs_frontend_pkg::inst_t          if_inst
);

    vs_frontend_pkg::addr_t pc;
    logic                   dmem_req;

    // Data side owns the port whenever it asks
    assign dmem_req = (dmem_command != vs_frontend_pkg::bus_none);

    //////////////////////////////////////////////////
    // Memory port arbitration
    //////////////////////////////////////////////////
    always_comb begin
        if (dmem_req) begin
            // Data request passes straight through
            proc2mem_command = dmem_command;
            proc2mem_addr    = dmem_addr;
            // Store data zero-extended to a full line
            proc2mem_data    = vs_frontend_pkg::mem_line_t'(dmem_data);
        end else begin
            // Instruction fetch, line aligned
            proc2mem_command = vs_frontend_pkg::bus_load;
            proc2mem_addr    = {pc[vs_frontend_pkg::xlen-1:3], 3'b000};
            proc2mem_data    = '0;
        end
    end

    //////////////////////////////////////////////////
    // Word select and push
    //////////////////////////////////////////////////

    // Fetch only when the port is free, no redirect, room in buffer
    assign if_valid = !dmem_req && !squash && !ib_full;
    assign if_pc    = pc;

    // Upper half holds the odd word of the line
    assign if_inst = pc[2] ? mem2proc_data[63:32] : mem2proc_data[31:0];

    // PC update
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= vs_frontend_pkg::reset_pc;
        end else if (squash) begin
            // Redirect wins over everything
            pc <= squash_pc;
        end else if (if_valid) begin
            pc <= pc + vs_frontend_pkg::addr_t'(4);
        end
        // Otherwise hold, stalled by data request or full buffer
    end

endmodule

/* hw/insn_buffer.sv */
//////////////////////////////////////////////////
// Instruction buffer
// Circular FIFO of PC and instruction pairs
// between fetch and dispatch, flushed on squash
//////////////////////////////////////////////////

module insn_buffer (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   squash,
    input  logic                   if_valid,
    input  vs_frontend_pkg::addr_t if_pc,
    input  vs_frontend_pkg::inst_t if_inst,
    input  logic                   ib_pop,
    output logic                   ib_full,
    output logic                   ib_valid,
    output vs_frontend_pkg::addr_t ib_pc,
    output vs_frontend_pkg::inst_t ib_inst
);

    // Entry storage
    vs_frontend_pkg::addr_t pc_mem   [vs_frontend_pkg::ib_depth];
    vs_frontend_pkg::inst_t inst_mem [vs_frontend_pkg::ib_depth];

    vs_frontend_pkg::ib_ptr_t   head;
    vs_frontend_pkg::ib_ptr_t   tail;
    vs_frontend_pkg::ib_count_t count;

    // Status
    assign ib_full  = (count == vs_frontend_pkg::ib_count_t'(vs_frontend_pkg::ib_depth));
    // Head hidden during a squash so nothing stale is popped
    assign ib_valid = (count != '0) && !squash;

    // Head entry
    assign ib_pc   = pc_mem[head];
    assign ib_inst = inst_mem[head];

    //////////////////////////////////////////////////
    // Storage write at tail
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (if_valid) begin
            pc_mem[tail]   <= if_pc;
            inst_mem[tail] <= if_inst;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (squash) begin
            // Flush beats any push or pop this cycle
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Pointers wrap naturally, depth is a power of two
            if (if_valid) begin
                tail <= tail + vs_frontend_pkg::ib_ptr_t'(1);
            end
            if (ib_pop) begin
                head <= head + vs_frontend_pkg::ib_ptr_t'(1);
            end
            // Push and pop together leave count unchanged
            case ({if_valid, ib_pop})
                2'b10:   count <= count + vs_frontend_pkg::ib_count_t'(1);
                2'b01:   count <= count - vs_frontend_pkg::ib_count_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/vs_frontend.sv */
//////////////////////////////////////////////////
// Front end top level
// Fetch, instruction buffer and dispatch on the
// shared processor memory port
//////////////////////////////////////////////////

module vs_frontend (
    input  logic                            clock,
    input  logic                            rst_n,
    // Back end control
    input  logic                            squash,
    input  vs_frontend_pkg::addr_t          squash_pc,
    input  logic                            dispatch_en,
    // Data side request
    input  vs_frontend_pkg::bus_cmd_t       dmem_command,
    input  vs_frontend_pkg::addr_t          dmem_addr,
    input  logic [vs_frontend_pkg::xlen-1:0] dmem_data,
    // Memory port, answered same cycle
    input  vs_frontend_pkg::mem_line_t      mem2proc_data,
    output vs_frontend_pkg::bus_cmd_t       proc2mem_command,
    output vs_frontend_pkg::addr_t          proc2mem_addr,
    output vs_frontend_pkg::mem_line_t      proc2mem_data,
    // Dispatch
    output logic                            dp_valid,
    output vs_frontend_pkg::addr_t          dp_pc,
    output vs_frontend_pkg::inst_t          dp_inst,
    output vs_frontend_pkg::inst_class_t    dp_class,
    output logic                            dp_has_dest,
    output vs_frontend_pkg::reg_idx_t       dp_dest_reg,
    output logic                            dp_illegal,
    output logic                            halted
);

    // Fetch to buffer
    logic                   if_valid;
    vs_frontend_pkg::addr_t if_pc;
    vs_frontend_pkg::inst_t if_inst;
    logic                   ib_full;

    // Buffer to dispatch
    logic                   ib_valid;
    vs_frontend_pkg::addr_t ib_pc;
    vs_frontend_pkg::inst_t ib_inst;
    logic                   ib_pop;

    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////
    fetch_stage u_fetch_stage (
        .clock            (clock),
        .rst_n            (rst_n),
        .squash           (squash),
        .squash_pc        (squash_pc),
        .ib_full          (ib_full),
        .dmem_command     (dmem_command),
        .dmem_addr        (dmem_addr),
        .dmem_data        (dmem_data),
        .mem2proc_data    (mem2proc_data),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .proc2mem_data    (proc2mem_data),
        .if_valid         (if_valid),
        .if_pc            (if_pc),
        .if_inst          (if_inst)
    );

    //////////////////////////////////////////////////
    // Instruction buffer
    //////////////////////////////////////////////////
    insn_buffer u_insn_buffer (
        .clock    (clock),
        .rst_n    (rst_n),
        .squash   (squash),
        .if_valid (if_valid),
        .if_pc    (if_pc),
        .if_inst  (if_inst),
        .ib_pop   (ib_pop),
        .ib_full  (ib_full),
        .ib_valid (ib_valid),
        .ib_pc    (ib_pc),
        .ib_inst  (ib_inst)
    );

    //////////////////////////////////////////////////
    // Dispatch
    //////////////////////////////////////////////////
    dispatch_stage u_dispatch_stage (
        .clock       (clock),
        .rst_n       (rst_n),
        .dispatch_en (dispatch_en),
        .ib_valid    (ib_valid),
        .ib_pc       (ib_pc),
        .ib_inst     (ib_inst),
        .ib_pop      (ib_pop),
        .dp_valid    (dp_valid),
        .dp_pc       (dp_pc),
        .dp_inst     (dp_inst),
        .dp_class    (dp_class),
        .dp_has_dest (dp_has_dest),
        .dp_dest_reg (dp_dest_reg),
        .dp_illegal  (dp_illegal),
        .halted      (halted)
    );

endmodule

/* hw/vs_frontend_pkg.sv */
//////////////////////////////////////////////////
// Front end shared definitions
// Widths, buffer sizing, bus commands and the
// RV32 opcode table used by fetch and dispatch
//////////////////////////////////////////////////

package vs_frontend_pkg;

    // Address and data word width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [63:0]     mem_line_t;
    typedef logic [4:0]      reg_idx_t;

    // Instruction buffer sizing, depth kept a power of two
    localparam int ib_depth = 8;

    typedef logic [$clog2(ib_depth)-1:0] ib_ptr_t;
    // One extra bit so a full buffer is distinct from empty
    typedef logic [$clog2(ib_depth):0]   ib_count_t;

    // Memory port command
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_cmd_t;

    // Decoded opcode class
    typedef enum logic [3:0] {
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_op_imm,
        cls_op,
        cls_system,
        cls_illegal
    } inst_class_t;

    //////////////////////////////////////////////////
    // RV32I base opcodes, low two bits always 11
    //////////////////////////////////////////////////
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

    // Full WFI encoding, halts dispatch
    localparam inst_t    inst_wfi = 32'h10500073;
    localparam reg_idx_t zero_reg = 5'd0;
    localparam addr_t    reset_pc = '0;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build the front end testbench with Verilator and run it
# The run counts as passed only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_vs_frontend \
    -f vs_frontend.f -o sim_tb_vs_frontend &&
./obj_dir/sim_tb_vs_frontend | tee /dev/stderr | grep -F -q '*** PASSED ***' &&
echo "Simulation run OK" ||
{ echo "Simulation run reported an error"; exit 1; }

/* verif/tb_checks.svh */
//////////////////////////////////////////////////
// Testbench compare tasks
// Typed value checks, error stop and the
// dispatch count wait used by the tests
//////////////////////////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

    // Stop at the first error
    task automatic stop_on_error();
        errors++;
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_plain(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_on_error();
    endtask

    //////////////////////////////////////////////////
    // Typed compares
    //////////////////////////////////////////////////
    task automatic check_addr(input string name, input vs_frontend_pkg::addr_t got,
                              input vs_frontend_pkg::addr_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_inst(input string name, input vs_frontend_pkg::inst_t got,
                              input vs_frontend_pkg::inst_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_class(input string name, input vs_frontend_pkg::inst_class_t got,
                               input vs_frontend_pkg::inst_class_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got %s expected %s",
                     $time, name, got.name(), want.name());
            stop_on_error();
        end
    endtask

    task automatic check_reg(input string name, input vs_frontend_pkg::reg_idx_t got,
                             input vs_frontend_pkg::reg_idx_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got x%0d expected x%0d", $time, name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, want);
            stop_on_error();
        end
    endtask

    // Memory port command and store line
    task automatic check_cmd(input string name, input vs_frontend_pkg::bus_cmd_t got,
                             input vs_frontend_pkg::bus_cmd_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got %s expected %s",
                     $time, name, got.name(), want.name());
            stop_on_error();
        end
    endtask

    task automatic check_line(input string name, input vs_frontend_pkg::mem_line_t got,
                              input vs_frontend_pkg::mem_line_t want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
            stop_on_error();
        end
    endtask

    // Count moves on the falling edge, read it on the rising one
    task automatic wait_dispatches(input int target, input int max_cycles);
        int n;
        n = 0;
        while (dispatched < target && n < max_cycles) begin
            @(posedge clock);
            n++;
        end
        if (dispatched < target) begin
            fail_plain("dispatch stopped before reaching the expected count");
        end
    endtask

`endif

/* verif/tb_vs_frontend.sv */
//////////////////////////////////////////////////
// Front end testbench
// Same cycle memory model, dispatch scoreboard and
// directed tests for flow, decode, stalls and WFI
//////////////////////////////////////////////////

module tb_vs_frontend;

    logic                             clock;
    logic                             rst_n;
    logic                             squash;
    vs_frontend_pkg::addr_t           squash_pc;
    logic                             dispatch_en;
    vs_frontend_pkg::bus_cmd_t        dmem_command;
    vs_frontend_pkg::addr_t           dmem_addr;
    logic [vs_frontend_pkg::xlen-1:0] dmem_data;
    vs_frontend_pkg::mem_line_t       mem2proc_data;
    vs_frontend_pkg::bus_cmd_t        proc2mem_command;
    vs_frontend_pkg::addr_t           proc2mem_addr;
    vs_frontend_pkg::mem_line_t       proc2mem_data;
    logic                             dp_valid;
    vs_frontend_pkg::addr_t           dp_pc;
    vs_frontend_pkg::inst_t           dp_inst;
    vs_frontend_pkg::inst_class_t     dp_class;
    logic                             dp_has_dest;
    vs_frontend_pkg::reg_idx_t        dp_dest_reg;
    logic                             dp_illegal;
    logic                             halted;

    // 64 lines of two words each
    vs_frontend_pkg::mem_line_t mem [64];
    // Program order still to be dispatched
    vs_frontend_pkg::addr_t     exp_q [$];
    int                         dispatched;
    int                         errors;
    logic [31:0]                lfsr_state;

    `include "tb_checks.svh"

    vs_frontend u_vs_frontend (.*);

    // Memory answers in the request cycle
    assign mem2proc_data = mem[proc2mem_addr[8:3]];

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Random source and memory model
    //////////////////////////////////////////////////

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Legal opcode with random upper fields
    function automatic vs_frontend_pkg::inst_t random_inst();
        logic [3:0]             sel;
        logic [6:0]             opc;
        vs_frontend_pkg::inst_t w;
        sel = 4'(take_bits(4));
        case (sel)
            4'd0:    opc = vs_frontend_pkg::opc_lui;
            4'd1:    opc = vs_frontend_pkg::opc_auipc;
            4'd2:    opc = vs_frontend_pkg::opc_jal;
            4'd3:    opc = vs_frontend_pkg::opc_jalr;
            4'd4:    opc = vs_frontend_pkg::opc_branch;
            4'd5:    opc = vs_frontend_pkg::opc_load;
            4'd6:    opc = vs_frontend_pkg::opc_store;
            4'd7:    opc = vs_frontend_pkg::opc_op;
            4'd8:    opc = vs_frontend_pkg::opc_system;
            default: opc = vs_frontend_pkg::opc_op_imm;
        endcase
        w = {25'(take_bits(25)), opc};
        // Only the planted WFI may halt dispatch
        if (w == vs_frontend_pkg::inst_wfi) begin
            w[20] = 1'b0;
        end
        return w;
    endfunction

    function automatic vs_frontend_pkg::inst_t word_at(input vs_frontend_pkg::addr_t a);
        return a[2] ? mem[a[8:3]][63:32] : mem[a[8:3]][31:0];
    endfunction

    task automatic put_word(input vs_frontend_pkg::addr_t a, input vs_frontend_pkg::inst_t w);
        if (a[2]) begin
            mem[a[8:3]][63:32] = w;
        end else begin
            mem[a[8:3]][31:0] = w;
        end
    endtask

    task automatic load_program();
        vs_frontend_pkg::inst_t lo;
        vs_frontend_pkg::inst_t hi;
        foreach (mem[i]) begin
            lo = random_inst();
            hi = random_inst();
            mem[i] = {hi, lo};
        end
        // Decode corner cases
        put_word(32'd32, 32'h00000013);  // addi x0, rd zero
        put_word(32'd36, 32'h0000007f);  // unknown opcode
        put_word(32'd40, 32'h00a00093);  // addi x1
        put_word(32'd44, 32'h00000001);  // compressed space
        put_word(32'd200, vs_frontend_pkg::inst_wfi);
    endtask

    //////////////////////////////////////////////////
    // Decode reference and scoreboard
    //////////////////////////////////////////////////
    function automatic vs_frontend_pkg::inst_class_t class_of(input vs_frontend_pkg::inst_t w);
        case (w[6:0])
            vs_frontend_pkg::opc_lui:    return vs_frontend_pkg::cls_lui;
            vs_frontend_pkg::opc_auipc:  return vs_frontend_pkg::cls_auipc;
            vs_frontend_pkg::opc_jal:    return vs_frontend_pkg::cls_jal;
            vs_frontend_pkg::opc_jalr:   return vs_frontend_pkg::cls_jalr;
            vs_frontend_pkg::opc_branch: return vs_frontend_pkg::cls_branch;
            vs_frontend_pkg::opc_load:   return vs_frontend_pkg::cls_load;
            vs_frontend_pkg::opc_store:  return vs_frontend_pkg::cls_store;
            vs_frontend_pkg::opc_op_imm: return vs_frontend_pkg::cls_op_imm;
            vs_frontend_pkg::opc_op:     return vs_frontend_pkg::cls_op;
            vs_frontend_pkg::opc_system: return vs_frontend_pkg::cls_system;
            default:                     return vs_frontend_pkg::cls_illegal;
        endcase
    endfunction

    function automatic logic writes_rd(input vs_frontend_pkg::inst_t w);
        vs_frontend_pkg::inst_class_t c;
        c = class_of(w);
        if (w[11:7] == vs_frontend_pkg::zero_reg) begin
            return 1'b0;
        end
        return c inside {vs_frontend_pkg::cls_lui, vs_frontend_pkg::cls_auipc,
                         vs_frontend_pkg::cls_jal, vs_frontend_pkg::cls_jalr,
                         vs_frontend_pkg::cls_load, vs_frontend_pkg::cls_op_imm,
                         vs_frontend_pkg::cls_op};
    endfunction

    task automatic expect_from(input vs_frontend_pkg::addr_t start);
        exp_q.delete();
        for (vs_frontend_pkg::addr_t a = start; a < 512; a += 4) begin
            exp_q.push_back(a);
        end
    endtask

    task automatic check_dispatch();
        vs_frontend_pkg::addr_t pc;
        vs_frontend_pkg::inst_t w;
        if (exp_q.size() == 0) begin
            fail_plain("dispatch seen with no expected PC left");
        end else begin
            pc = exp_q.pop_front();
            w  = word_at(pc);
            check_addr("dp_pc", dp_pc, pc);
            check_inst("dp_inst", dp_inst, w);
            check_class("dp_class", dp_class, class_of(w));
            check_bit("dp_has_dest", dp_has_dest, writes_rd(w));
            check_reg("dp_dest_reg", dp_dest_reg,
                      writes_rd(w) ? w[11:7] : vs_frontend_pkg::zero_reg);
            check_bit("dp_illegal", dp_illegal,
                      (w[1:0] != 2'b11) || (class_of(w) == vs_frontend_pkg::cls_illegal));
            dispatched++;
        end
    endtask

    // Outputs settle after the rising edge
    always @(negedge clock) begin
        if (rst_n && dp_valid) begin
            check_dispatch();
        end
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic sequential_flow();
        @(posedge clock);
        dispatch_en <= 1'b1;
        wait_dispatches(8, 100);
    endtask

    // PCs 32 to 44 hold the corner words
    task automatic decode_mix();
        @(posedge clock);
        dispatch_en <= 1'b1;
        wait_dispatches(16, 100);
    endtask

    task automatic back_pressure();
        @(posedge clock);
        dispatch_en <= 1'b0;
        // Last pop may still show up once
        @(negedge clock);
        repeat (29) begin
            @(negedge clock);
            check_bit("dp_valid", dp_valid, 1'b0);
        end
        check_bit("ib_full", u_vs_frontend.ib_full, 1'b1);
        @(posedge clock);
        dispatch_en <= 1'b1;
        wait_dispatches(dispatched + 12, 100);
    endtask

    task automatic data_priority();
        vs_frontend_pkg::addr_t a;
        logic [31:0]            d;
        for (int i = 0; i < 6; i++) begin
            a = take_bits(32);
            d = take_bits(32);
            @(posedge clock);
            dmem_command <= vs_frontend_pkg::bus_store;
            dmem_addr    <= a;
            dmem_data    <= d;
            @(negedge clock);
            check_cmd("proc2mem_command", proc2mem_command, vs_frontend_pkg::bus_store);
            check_addr("proc2mem_addr", proc2mem_addr, a);
            check_line("proc2mem_data", proc2mem_data, {32'h0, d});
        end
        @(posedge clock);
        dmem_command <= vs_frontend_pkg::bus_none;
        wait_dispatches(dispatched + 8, 100);
    endtask

    task automatic squash_redirect();
        @(posedge clock);
        dispatch_en <= 1'b0;
        // Drain the dispatch register
        repeat (2) @(negedge clock);
        @(posedge clock);
        squash    <= 1'b1;
        squash_pc <= vs_frontend_pkg::addr_t'(64);
        expect_from(vs_frontend_pkg::addr_t'(64));
        @(negedge clock);
        check_bit("ib_valid", u_vs_frontend.ib_valid, 1'b0);
        @(posedge clock);
        squash      <= 1'b0;
        dispatch_en <= 1'b1;
        wait_dispatches(dispatched + 6, 100);
    endtask

    task automatic wfi_halt();
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!halted && n < 300);
        if (!halted) begin
            fail_plain("halted never rose after the WFI at PC 200");
        end else begin
            // WFI leaves dispatch in the cycle halted rises
            check_bit("dp_valid", dp_valid, 1'b1);
            check_addr("dp_pc", dp_pc, vs_frontend_pkg::addr_t'(200));
            check_inst("dp_inst", dp_inst, vs_frontend_pkg::inst_wfi);
            repeat (40) begin
                @(negedge clock);
                check_bit("dp_valid", dp_valid, 1'b0);
            end
            check_bit("halted", halted, 1'b1);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        rst_n        = 1'b0;
        squash       = 1'b0;
        squash_pc    = '0;
        dispatch_en  = 1'b0;
        dmem_command = vs_frontend_pkg::bus_none;
        dmem_addr    = '0;
        dmem_data    = '0;
        dispatched   = 0;
        errors       = 0;
        lfsr_state   = 32'd91063;
        load_program();
        expect_from(vs_frontend_pkg::reset_pc);

        // Idle state while reset is held
        repeat (7) @(posedge clock);
        @(negedge clock);
        check_cmd("proc2mem_command", proc2mem_command, vs_frontend_pkg::bus_load);
        check_addr("proc2mem_addr", proc2mem_addr, vs_frontend_pkg::reset_pc);
        check_bit("dp_valid", dp_valid, 1'b0);
        check_bit("halted", halted, 1'b0);
        check_bit("ib_valid", u_vs_frontend.ib_valid, 1'b0);
        @(posedge clock);
        rst_n <= 1'b1;

        sequential_flow();
        decode_mix();
        back_pressure();
        data_priority();
        squash_redirect();
        wfi_halt();

        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* vs_frontend.f */
+incdir+verif
hw/vs_frontend_pkg.sv
hw/fetch_stage.sv
hw/insn_buffer.sv
hw/dispatch_stage.sv
hw/vs_frontend.sv
verif/tb_vs_frontend.sv
